/* logic/gdw_settings.svh */
// Width, depth and APB register map macros for the graph data write-back path
`ifndef GDW_SETTINGS_SVH
`define GDW_SETTINGS_SVH

// Cacheline and element geometry
`define GDW_LINE_BITS 512
`define GDW_ELEM_BITS 32
`define GDW_ELEM_BYTES (`GDW_ELEM_BITS / 8)
`define GDW_ELEM_SHIFT $clog2(`GDW_ELEM_BYTES)
`define GDW_LINE_BYTES (`GDW_LINE_BITS / 8)
`define GDW_SLOT_COUNT (`GDW_LINE_BITS / `GDW_ELEM_BITS)
`define GDW_SLOT_BITS $clog2(`GDW_SLOT_COUNT)

// Element write fields
`define GDW_INDEX_BITS 24
`define GDW_CU_ID_BITS 8

// Memory side
`define GDW_ADDR_BITS 32
`define GDW_QUEUE_DEPTH 8
`define GDW_QPTR_BITS $clog2(`GDW_QUEUE_DEPTH)

// APB map
`define GDW_APB_ADDR_BITS 8
`define GDW_APB_DATA_BITS 32
`define GDW_REG_CTRL 8'h00
`define GDW_REG_BASE 8'h04

`endif

/* logic/gdw_pkg.sv */
// Element, command, data beat and configuration types plus state and opcode enums
`include "gdw_settings.svh"

package gdw_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Enumerations
	////////////////////////////////////////////////////////////////////////////

	// Abort policy, encoded straight from control bits 3:1
	typedef enum logic [2:0] {
		STRICT = 3'd0,
		ABORT  = 3'd1,
		PAGE   = 3'd2,
		SPEC   = 3'd3,
		PREF   = 3'd4
	} abort_mode_e;

	// Memory write opcodes, CAPI style encoding
	typedef enum logic [12:0] {
		WRITE_NA = 13'h0D00,
		WRITE_MS = 13'h0D60
	} write_cmd_e;

	typedef enum logic {
		IDLE   = 1'b0,
		ACCESS = 1'b1
	} apb_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Structures
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                        valid;
		logic [`GDW_INDEX_BITS-1:0]  index;
		logic [`GDW_ELEM_BITS-1:0]   data;
		logic [`GDW_CU_ID_BITS-1:0]  cu_id;
	} elem_write_t;

	// Register view handed to the pipeline
	typedef struct packed {
		logic                        enable;
		abort_mode_e                 abort_mode;
		logic                        write_ms;
		logic [`GDW_ADDR_BITS-1:0]   base_addr;
	} gdw_config_t;

	typedef struct packed {
		logic                        valid;
		logic [`GDW_ADDR_BITS-1:0]   address;
		logic [7:0]                  size;
		write_cmd_e                  command;
		abort_mode_e                 abort_mode;
		logic [`GDW_CU_ID_BITS-1:0]  cu_id;
		logic [`GDW_SLOT_BITS-1:0]   slot;
	} write_command_t;

	typedef struct packed {
		logic                        valid;
		logic [`GDW_CU_ID_BITS-1:0]  cu_id;
		logic [`GDW_SLOT_BITS-1:0]   slot;
		logic [`GDW_LINE_BITS-1:0]   line;
		logic [`GDW_LINE_BYTES-1:0]  byte_en;
	} write_data_t;

endpackage

/* logic/gdw_config_regs.sv */
// APB slave with the control and base address registers
`include "gdw_settings.svh"

module gdw_config_regs
	import gdw_pkg::*;
(
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [`GDW_APB_ADDR_BITS-1:0] paddr,
	input  logic [`GDW_APB_DATA_BITS-1:0] pwdata,
	output logic [`GDW_APB_DATA_BITS-1:0] prdata,
	output logic                          pready,
	output logic                          pslverr,
	output gdw_config_t                   cfg
);

	apb_state_e                state;
	logic                      access;
	logic                      mapped;
	logic                      enable;
	abort_mode_e               abort_mode;
	logic                      write_ms;
	logic [`GDW_ADDR_BITS-1:0] base_addr;

	// Codes past the last policy fall back to STRICT
	function automatic abort_mode_e decode_abort(input logic [2:0] code);
		if (code > PREF) begin
			return STRICT;
		end
		return abort_mode_e'(code);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Transfer phase tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else if (state == IDLE) begin
			if (psel) begin
				state <= ACCESS;
			end
		end else begin
			state <= IDLE;
		end
	end

	assign access  = (state == ACCESS) && psel && penable;
	assign mapped  = (paddr == `GDW_REG_CTRL) || (paddr == `GDW_REG_BASE);
	assign pready  = (state == ACCESS);
	assign pslverr = access && !mapped;

	////////////////////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable     <= 1'b0;
			abort_mode <= STRICT;
			write_ms   <= 1'b0;
			base_addr  <= '0;
		end else if (access && pwrite) begin
			if (paddr == `GDW_REG_CTRL) begin
				// Bit 0 enable, 3:1 abort code, 4 cache allocating write
				enable     <= pwdata[0];
				abort_mode <= decode_abort(pwdata[3:1]);
				write_ms   <= pwdata[4];
			end else if (paddr == `GDW_REG_BASE) begin
				base_addr <= pwdata;
			end
		end
	end

	// Read mux
	always_comb begin
		prdata = '0;
		if (paddr == `GDW_REG_CTRL) begin
			prdata[0]   = enable;
			prdata[3:1] = abort_mode;
			prdata[4]   = write_ms;
		end else if (paddr == `GDW_REG_BASE) begin
			prdata = base_addr;
		end
	end

	always_comb begin
		cfg.enable     = enable;
		cfg.abort_mode = abort_mode;
		cfg.write_ms   = write_ms;
		cfg.base_addr  = base_addr;
	end

endmodule

/* logic/write_command_builder.sv */
// First pipeline stage that latches an element write and forms its write command
`include "gdw_settings.svh"

module write_command_builder
	import gdw_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  gdw_config_t    cfg,
	input  elem_write_t    elem_in,
	input  logic           elem_take,
	output write_command_t cmd_stage,
	output elem_write_t    elem_stage
);

	logic           stage_valid;
	write_command_t cmd_next;
	write_command_t cmd_q;
	elem_write_t    elem_q;

	////////////////////////////////////////////////////////////////////////////
	// Command fields for the element on the input
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cmd_next       = '0;
		cmd_next.valid = 1'b1;

		// Element address inside the data array
		cmd_next.address = cfg.base_addr +
			(`GDW_ADDR_BITS'(elem_in.index) << `GDW_ELEM_SHIFT);

		cmd_next.size       = 8'(`GDW_ELEM_BYTES);
		cmd_next.abort_mode = cfg.abort_mode;
		cmd_next.cu_id      = elem_in.cu_id;

		// Which element slot of the cacheline is written
		cmd_next.slot = elem_in.index[`GDW_SLOT_BITS-1:0];

		if (cfg.write_ms) begin
			cmd_next.command = WRITE_MS;
		end else begin
			cmd_next.command = WRITE_NA;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////////////

	// Valid follows the take strobe every cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= elem_take;
		end
	end

	// Payload only loads on an accepted element
	always_ff @(posedge clock) begin
		if (elem_take) begin
			cmd_q  <= cmd_next;
			elem_q <= elem_in;
		end
	end

	always_comb begin
		cmd_stage        = cmd_q;
		cmd_stage.valid  = stage_valid;
		elem_stage       = elem_q;
		elem_stage.valid = stage_valid;
	end

endmodule

/* logic/data_line_packer.sv */
// Second pipeline stage that byte swaps the element and places it in a cacheline
`include "gdw_settings.svh"

module data_line_packer
	import gdw_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  write_command_t cmd_stage,
	input  elem_write_t    elem_stage,
	output write_command_t cmd_pack,
	output write_data_t    data_pack
);

	logic           pack_valid;
	logic           stage_valid;
	write_data_t    data_next;
	write_command_t cmd_q;
	write_data_t    data_q;

	// Host order to memory order
	function automatic logic [`GDW_ELEM_BITS-1:0] swap_bytes(
		input logic [`GDW_ELEM_BITS-1:0] value
	);
		logic [`GDW_ELEM_BITS-1:0] swapped;
		for (int b = 0; b < `GDW_ELEM_BYTES; b++) begin
			swapped[b*8 +: 8] = value[(`GDW_ELEM_BYTES-1-b)*8 +: 8];
		end
		return swapped;
	endfunction

	assign stage_valid = cmd_stage.valid && elem_stage.valid;

	// Zero line with one element slot filled
	always_comb begin
		data_next       = '0;
		data_next.valid = 1'b1;
		data_next.cu_id = elem_stage.cu_id;
		data_next.slot  = cmd_stage.slot;
		data_next.line[cmd_stage.slot*`GDW_ELEM_BITS +: `GDW_ELEM_BITS] =
			swap_bytes(elem_stage.data);
		data_next.byte_en[cmd_stage.slot*`GDW_ELEM_BYTES +: `GDW_ELEM_BYTES] = '1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pack_valid <= 1'b0;
		end else begin
			pack_valid <= stage_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (stage_valid) begin
			cmd_q  <= cmd_stage;
			data_q <= data_next;
		end
	end

	always_comb begin
		cmd_pack        = cmd_q;
		cmd_pack.valid  = pack_valid;
		data_pack       = data_q;
		data_pack.valid = pack_valid;
	end

endmodule

/* logic/write_output_queue.sv */
// Output FIFO of command and data pairs with credit based element ready
`include "gdw_settings.svh"

module write_output_queue
	import gdw_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  logic           enable,
	input  write_command_t cmd_pack,
	input  write_data_t    data_pack,
	input  logic [1:0]     inflight,
	output logic           elem_ready,
	output write_command_t cmd_out,
	output write_data_t    data_out,
	input  logic           out_ready
);

	typedef struct packed {
		write_command_t cmd;
		write_data_t    data;
	} queue_entry_t;

	queue_entry_t              mem [`GDW_QUEUE_DEPTH];
	queue_entry_t              head;
	logic [`GDW_QPTR_BITS-1:0] wr_ptr;
	logic [`GDW_QPTR_BITS-1:0] rd_ptr;
	logic [`GDW_QPTR_BITS:0]   count;
	logic                      not_empty;
	logic                      push;
	logic                      pop;

	assign not_empty = (count != '0);
	assign push      = cmd_pack.valid && data_pack.valid;
	assign pop       = not_empty && out_ready;

	// Admit only what still fits once the stages drain
	assign elem_ready = enable && ((count + {2'b00, inflight}) < `GDW_QUEUE_DEPTH);

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == `GDW_QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == `GDW_QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= '{cmd: cmd_pack, data: data_pack};
		end
	end

	// Head entry held until popped
	always_comb begin
		head           = mem[rd_ptr];
		cmd_out        = head.cmd;
		cmd_out.valid  = not_empty;
		data_out       = head.data;
		data_out.valid = not_empty;
	end

endmodule

/* logic/gdw_top.sv */
// Top level of the write-back path with APB registers and three pipeline stages
`include "gdw_settings.svh"

module gdw_top
	import gdw_pkg::*;
(
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [`GDW_APB_ADDR_BITS-1:0] paddr,
	input  logic [`GDW_APB_DATA_BITS-1:0] pwdata,
	output logic [`GDW_APB_DATA_BITS-1:0] prdata,
	output logic                          pready,
	output logic                          pslverr,
	input  elem_write_t                   elem_in,
	output logic                          elem_ready,
	output write_command_t                cmd_out,
	output write_data_t                   data_out,
	input  logic                          out_ready
);

	gdw_config_t    cfg;
	logic           elem_take;
	write_command_t cmd_stage;
	elem_write_t    elem_stage;
	write_command_t cmd_pack;
	write_data_t    data_pack;
	logic [1:0]     inflight;

	assign elem_take = elem_in.valid && elem_ready;

	// Elements sitting in stages one and two
	assign inflight = {1'b0, cmd_stage.valid} + {1'b0, cmd_pack.valid};

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	gdw_config_regs i_config_regs (
		.clock   (clock),
		.rstn    (rstn),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.cfg     (cfg)
	);

	write_command_builder i_builder (
		.clock      (clock),
		.rstn       (rstn),
		.cfg        (cfg),
		.elem_in    (elem_in),
		.elem_take  (elem_take),
		.cmd_stage  (cmd_stage),
		.elem_stage (elem_stage)
	);

	data_line_packer i_packer (
		.clock      (clock),
		.rstn       (rstn),
		.cmd_stage  (cmd_stage),
		.elem_stage (elem_stage),
		.cmd_pack   (cmd_pack),
		.data_pack  (data_pack)
	);

	write_output_queue i_queue (
		.clock      (clock),
		.rstn       (rstn),
		.enable     (cfg.enable),
		.cmd_pack   (cmd_pack),
		.data_pack  (data_pack),
		.inflight   (inflight),
		.elem_ready (elem_ready),
		.cmd_out    (cmd_out),
		.data_out   (data_out),
		.out_ready  (out_ready)
	);

endmodule

/* dv/gdw_properties.sv */
// Bound assertions on output hold, reset values and byte-enable shape
`include "gdw_settings.svh"

module gdw_properties
	import gdw_pkg::*;
(
	input logic           clock,
	input logic           rstn,
	input logic           elem_ready,
	input write_command_t cmd_out,
	input write_data_t    data_out,
	input logic           out_ready
);

	// Head pair is held until the memory side takes it
	property head_held_until_taken;
		@(posedge clock) disable iff (!rstn)
		(cmd_out.valid && !out_ready) |=>
			(cmd_out.valid && $stable(cmd_out) && $stable(data_out));
	endproperty

	property quiet_in_reset;
		@(posedge clock)
		!rstn |-> (!elem_ready && !cmd_out.valid && !data_out.valid);
	endproperty

	// One element slot per beat
	property one_slot_enabled;
		@(posedge clock) disable iff (!rstn)
		data_out.valid |-> ($countones(data_out.byte_en) == `GDW_ELEM_BYTES);
	endproperty

	a_head_held: assert property (head_held_until_taken)
		else $error("Output pair dropped or changed before out_ready");

	a_quiet_in_reset: assert property (quiet_in_reset)
		else $error("Handshake outputs active during reset");

	a_one_slot: assert property (one_slot_enabled)
		else $error("Byte-enable mask does not mark exactly one element slot");

endmodule

bind gdw_top gdw_properties i_properties (
	.clock      (clock),
	.rstn       (rstn),
	.elem_ready (elem_ready),
	.cmd_out    (cmd_out),
	.data_out   (data_out),
	.out_ready  (out_ready)
);

/* dv/gdw_tb.sv */
// Testbench with APB setup, random element traffic, back-pressure and a reference model
`include "gdw_settings.svh"

module gdw_tb
	import gdw_pkg::*;
();

	localparam int CLK_HALF       = 4;
	localparam int RESET_CYCLES   = 4;
	localparam int OFF_CYCLES     = 12;
	localparam int RUN_CYCLES     = 250;
	localparam int STALL_CYCLES   = 24;
	localparam int RECOVER_CYCLES = 40;
	localparam int REPROG_CYCLES  = 200;
	localparam int LATENCY_CYCLES = 3;
	// APB transfers and the final drain come on top of the traffic phases
	localparam int PLANNED_CYCLES = RESET_CYCLES + OFF_CYCLES + RUN_CYCLES + STALL_CYCLES +
		RECOVER_CYCLES + REPROG_CYCLES + 70;
	localparam int TIMEOUT_CYCLES = 7 * PLANNED_CYCLES;

	logic                          clock;
	logic                          rstn;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [`GDW_APB_ADDR_BITS-1:0] paddr;
	logic [`GDW_APB_DATA_BITS-1:0] pwdata;
	logic [`GDW_APB_DATA_BITS-1:0] prdata;
	logic                          pready;
	logic                          pslverr;
	elem_write_t                   elem_in;
	logic                          elem_ready;
	write_command_t                cmd_out;
	write_data_t                   data_out;
	logic                          out_ready;

	integer seed;
	int     cycle_count;
	int     accepted;
	int     popped;

	// Shadow of the programmed registers
	logic                      sh_en;
	abort_mode_e               sh_abort;
	logic                      sh_ms;
	logic [`GDW_ADDR_BITS-1:0] sh_base;

	write_command_t exp_cmd_q[$];
	write_data_t    exp_data_q[$];
	// Cycle in which each outstanding element was taken
	int             accept_cycle_q[$];

	gdw_top i_dut (
		.clock      (clock),
		.rstn       (rstn),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.elem_in    (elem_in),
		.elem_ready (elem_ready),
		.cmd_out    (cmd_out),
		.data_out   (data_out),
		.out_ready  (out_ready)
	);

	initial clock = 1'b0;
	always #(CLK_HALF) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [`GDW_LINE_BITS-1:0] expected,
		input logic [`GDW_LINE_BITS-1:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h",
				$time, name, expected, actual);
			stop_on_error($sformatf("Wrong value on %s", name));
		end
	endtask

	function automatic logic percent_hit(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic write_command_t predict_command(input elem_write_t e);
		write_command_t c;
		c            = '0;
		c.valid      = 1'b1;
		c.address    = sh_base + `GDW_ADDR_BITS'(e.index) * `GDW_ELEM_BYTES;
		c.size       = 8'd4;
		c.command    = sh_ms ? WRITE_MS : WRITE_NA;
		c.abort_mode = sh_abort;
		c.cu_id      = e.cu_id;
		c.slot       = 4'(e.index % 16);
		return c;
	endfunction

	function automatic write_data_t predict_data(input elem_write_t e);
		logic [`GDW_ELEM_BITS-1:0] swapped;
		logic [3:0]                slot;
		write_data_t               d;
		slot    = 4'(e.index % 16);
		// Byte reversal into memory order
		swapped = {e.data[7:0], e.data[15:8], e.data[23:16], e.data[31:24]};
		d         = '0;
		d.valid   = 1'b1;
		d.cu_id   = e.cu_id;
		d.slot    = slot;
		d.line    = `GDW_LINE_BITS'(swapped) << (slot * `GDW_ELEM_BITS);
		d.byte_en = 64'hF << (slot * 4);
		return d;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// APB access
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clock);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		#1;
		check_value("pready in setup phase", '0, 512'(pready));
		@(negedge clock);
		penable = 1'b1;
		#1;
		// Two cycle transfer, ready in the first access cycle
		check_value("pready in access phase", 512'(1), 512'(pready));
		rdata = prdata;
		err   = pslverr;
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_register(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		logic        err;
		bus_transfer(1'b1, addr, wdata, rdata, err);
		check_value("pslverr on write", '0, 512'(err));
		if (addr == `GDW_REG_CTRL) begin
			sh_en    = wdata[0];
			sh_abort = (wdata[3:1] > 3'd4) ? STRICT : abort_mode_e'(wdata[3:1]);
			sh_ms    = wdata[4];
		end else begin
			sh_base = wdata;
		end
	endtask

	task automatic read_register(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] rdata;
		logic        err;
		bus_transfer(1'b0, addr, '0, rdata, err);
		check_value("pslverr on read", '0, 512'(err));
		check_value("prdata", 512'(expected), 512'(rdata));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Element traffic
	////////////////////////////////////////////////////////////////////////////

	task automatic observe_cycle();
		logic           exp_ready;
		logic           exp_valid;
		write_command_t exp_cmd;
		write_data_t    exp_data;
		// Credit counts everything accepted and not yet popped
		exp_ready = sh_en && (exp_cmd_q.size() < `GDW_QUEUE_DEPTH);
		// Oldest element reaches the queue head a fixed latency after it was taken
		exp_valid = (accept_cycle_q.size() != 0) &&
			(cycle_count >= accept_cycle_q[0] + LATENCY_CYCLES);
		check_value("elem_ready", 512'(exp_ready), 512'(elem_ready));
		check_value("cmd_out.valid", 512'(exp_valid), 512'(cmd_out.valid));
		check_value("data_out.valid", 512'(exp_valid), 512'(data_out.valid));
		if (exp_valid && out_ready) begin
			exp_cmd  = exp_cmd_q.pop_front();
			exp_data = exp_data_q.pop_front();
			accept_cycle_q.delete(0);
			check_value("cmd_out.address", 512'(exp_cmd.address), 512'(cmd_out.address));
			check_value("cmd_out.size", 512'(exp_cmd.size), 512'(cmd_out.size));
			check_value("cmd_out.command", 512'(exp_cmd.command), 512'(cmd_out.command));
			check_value("cmd_out.abort_mode", 512'(exp_cmd.abort_mode),
				512'(cmd_out.abort_mode));
			check_value("cmd_out.cu_id", 512'(exp_cmd.cu_id), 512'(cmd_out.cu_id));
			check_value("cmd_out.slot", 512'(exp_cmd.slot), 512'(cmd_out.slot));
			check_value("data_out.cu_id", 512'(exp_data.cu_id), 512'(data_out.cu_id));
			check_value("data_out.slot", 512'(exp_data.slot), 512'(data_out.slot));
			check_value("data_out.line", exp_data.line, data_out.line);
			check_value("data_out.byte_en", 512'(exp_data.byte_en), 512'(data_out.byte_en));
			popped++;
		end
		if (elem_in.valid && elem_ready) begin
			exp_cmd_q.push_back(predict_command(elem_in));
			exp_data_q.push_back(predict_data(elem_in));
			accept_cycle_q.push_back(cycle_count);
			accepted++;
		end
	endtask

	task automatic drive_traffic(input int cycles, input int valid_pct, input int ready_pct);
		for (int c = 0; c < cycles; c++) begin
			@(negedge clock);
			elem_in.valid = percent_hit(valid_pct);
			elem_in.index = 24'($random(seed));
			elem_in.data  = $random(seed);
			elem_in.cu_id = 8'($random(seed));
			out_ready     = percent_hit(ready_pct);
			#1;
			observe_cycle();
		end
	endtask

	// Watchdog
	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				stop_on_error($sformatf("Timeout after %0d cycles", cycle_count));
			end
		end
	end

	initial begin
		logic [31:0] rdata;
		logic        err;
		seed      = 32'h393;
		rstn      = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		elem_in   = '0;
		out_ready = 1'b0;
		sh_en     = 1'b0;
		sh_abort  = STRICT;
		sh_ms     = 1'b0;
		sh_base   = '0;
		accepted  = 0;
		popped    = 0;

		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		check_value("elem_ready in reset", '0, 512'(elem_ready));
		check_value("cmd_out.valid in reset", '0, 512'(cmd_out.valid));
		check_value("data_out.valid in reset", '0, 512'(data_out.valid));
		check_value("pslverr in reset", '0, 512'(pslverr));
		@(negedge clock);
		rstn = 1'b1;

		// Register access, unmapped offsets and abort code clamp
		write_register(`GDW_REG_BASE, 32'h1000_0000);
		read_register(`GDW_REG_BASE, 32'h1000_0000);
		write_register(`GDW_REG_CTRL, 32'h0000_0014);
		read_register(`GDW_REG_CTRL, 32'h0000_0014);
		write_register(`GDW_REG_CTRL, 32'h0000_000E);
		read_register(`GDW_REG_CTRL, 32'h0000_0000);
		bus_transfer(1'b0, 8'h08, '0, rdata, err);
		check_value("pslverr on unmapped read", 512'(1), 512'(err));
		bus_transfer(1'b1, 8'h0C, 32'hFFFF_FFFF, rdata, err);
		check_value("pslverr on unmapped write", 512'(1), 512'(err));
		read_register(`GDW_REG_BASE, 32'h1000_0000);

		// Disabled path takes nothing
		drive_traffic(OFF_CYCLES, 100, 100);
		// Element input idle while the enable write is in progress
		drive_traffic(1, 0, 100);

		// Enabled with SPEC abort mode and plain writes
		write_register(`GDW_REG_CTRL, 32'h0000_0007);
		drive_traffic(RUN_CYCLES, 60, 70);

		// Memory side stalls until the credit runs out
		drive_traffic(STALL_CYCLES, 100, 0);
		check_value("elements outstanding when full", 512'(`GDW_QUEUE_DEPTH),
			512'(exp_cmd_q.size()));
		check_value("elem_ready when full", '0, 512'(elem_ready));
		drive_traffic(RECOVER_CYCLES, 60, 100);

		// New base and cache allocating writes while traffic flows
		fork
			drive_traffic(REPROG_CYCLES, 70, 70);
			begin
				repeat (REPROG_CYCLES / 3) @(negedge clock);
				write_register(`GDW_REG_BASE, 32'h2000_0040);
				write_register(`GDW_REG_CTRL, 32'h0000_0013);
			end
		join

		while (popped != accepted) begin
			drive_traffic(1, 0, 100);
		end
		drive_traffic(8, 0, 100);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* build.f */
+incdir+logic
logic/gdw_pkg.sv
logic/gdw_config_regs.sv
logic/write_command_builder.sv
logic/data_line_packer.sv
logic/write_output_queue.sv
logic/gdw_top.sv
dv/gdw_properties.sv
dv/gdw_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the write-back path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module gdw_tb -o gdw_sim

sim_output="$(./obj_dir/gdw_sim 2>&1 || true)"
echo "$sim_output"

if grep -qF "Simulation finished: PASS" <<< "$sim_output"; then
	exit 0
fi
exit 1
